// File: ild_pkg.sv
`default_nettype none

package ild_pkg;

    // instruction store geometry
    localparam int ADDR_WIDTH = 4;
    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int INSTR_WIDTH = 38;

    // framing of one instruction on the serial line
    localparam int BYTES_PER_INSTR = 6;
    localparam int SLOT_WIDTH = $clog2(BYTES_PER_INSTR);
    // ascii '$' closes every data byte
    localparam logic [7:0] SEP_BYTE = 8'h24;

    // operating modes, value 3 falls back to fetch
    localparam logic [1:0] MODE_LOAD = 2'd0;
    localparam logic [1:0] MODE_DEBUG = 2'd1;
    localparam logic [1:0] MODE_FETCH = 2'd2;

    // uart bit timing
    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_TIMER_WIDTH = $clog2(CLKS_PER_BIT);

    // receiver fsm states
    localparam logic [1:0] RX_IDLE = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA = 2'd2;
    localparam logic [1:0] RX_STOP = 2'd3;

endpackage

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx import ild_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       rx,
    output logic [7:0]      rx_byte,
    output logic            rx_valid
);

    // two-flop synchronizer plus one delayed copy for edge detection
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    logic [1:0]                 state;
    logic [BIT_TIMER_WIDTH-1:0] timer;
    logic [2:0]                 bit_idx;
    logic                       bit_end;
    logic                       half_bit;

    // line idles high, so the flops come out of reset high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // timer marks the middle of the start bit and the middle of every later bit
    assign half_bit = (timer == BIT_TIMER_WIDTH'(CLKS_PER_BIT / 2 - 1));
    assign bit_end = (timer == BIT_TIMER_WIDTH'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RX_IDLE;
            timer <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end else begin
            // strobe lasts a single cycle
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    timer <= '0;
                    bit_idx <= '0;
                    // falling edge starts a frame
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_bit) begin
                        timer <= '0;
                        // a glitch that is high again at mid bit is no start bit
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        timer <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        timer <= '0;
                        state <= RX_IDLE;
                        // framing error drops the byte silently
                        rx_valid <= rx_sync;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: instr_assembler.sv
`timescale 1ns/1ns
`default_nettype none

module instr_assembler import ild_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [1:0]             mode,
    input  wire logic [7:0]             rx_byte,
    input  wire logic                   rx_valid,
    output logic                        wr_valid,
    output logic [ADDR_WIDTH-1:0]       wr_addr,
    output logic [INSTR_WIDTH-1:0]      wr_word,
    output logic [ADDR_WIDTH:0]         instr_count
);

    // one slot per data byte of the instruction
    logic [7:0]            slot [BYTES_PER_INSTR];
    logic [SLOT_WIDTH-1:0] slot_idx;
    logic [ADDR_WIDTH-1:0] wr_ptr;

    logic is_sep;
    logic last_slot;
    logic frame_done;

    assign is_sep = (rx_byte == SEP_BYTE);
    assign last_slot = (slot_idx == SLOT_WIDTH'(BYTES_PER_INSTR - 1));
    // separator closing slot 5 completes an instruction
    assign frame_done = (mode == MODE_LOAD) && rx_valid && is_sep && last_slot;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_idx <= '0;
            wr_ptr <= '0;
            wr_valid <= 1'b0;
            instr_count <= '0;
            for (int i = 0; i < BYTES_PER_INSTR; i++) begin
                slot[i] <= '0;
            end
        end else begin
            wr_valid <= 1'b0;
            if (mode != MODE_LOAD) begin
                // outside load mode a half built frame is thrown away
                slot_idx <= '0;
                for (int i = 0; i < BYTES_PER_INSTR; i++) begin
                    slot[i] <= '0;
                end
            end else if (rx_valid) begin
                if (!is_sep) begin
                    // later data bytes overwrite earlier ones in the same slot
                    slot[slot_idx] <= rx_byte;
                end else if (last_slot) begin
                    slot_idx <= '0;
                    wr_valid <= 1'b1;
                    // write pointer wraps around the store
                    wr_ptr <= wr_ptr + 1'b1;
                    // count stops once it reaches DEPTH
                    if (!instr_count[ADDR_WIDTH]) begin
                        instr_count <= instr_count + 1'b1;
                    end
                end else begin
                    slot_idx <= slot_idx + 1'b1;
                end
            end
        end
    end

    // word and address captured alongside the write strobe
    // top bits come from the low nibble of slot 0 and two bits of slot 1
    always_ff @(posedge clk) begin
        if (frame_done) begin
            wr_addr <= wr_ptr;
            wr_word <= {slot[0][3:0], slot[1][1:0], slot[2], slot[3], slot[4], slot[5]};
        end
    end

endmodule

`default_nettype wire

// File: instr_ram.sv
`timescale 1ns/1ns
`default_nettype none

module instr_ram import ild_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [1:0]             mode,
    input  wire logic                   debug,
    input  wire logic [ADDR_WIDTH-1:0]  fetch_addr,
    input  wire logic                   wr_valid,
    input  wire logic [ADDR_WIDTH-1:0]  wr_addr,
    input  wire logic [INSTR_WIDTH-1:0] wr_word,
    output logic [INSTR_WIDTH-1:0]      instr_out
);

    logic [INSTR_WIDTH-1:0] mem [DEPTH];

    // pushbutton synchronizer and rising edge detector
    logic dbg_meta;
    logic dbg_sync;
    logic dbg_prev;
    logic dbg_rise;

    // debug walk pointer
    logic [ADDR_WIDTH-1:0] dbg_ptr;
    logic [ADDR_WIDTH-1:0] dbg_next;
    logic                  can_step;

    // store is cleared on reset so an empty slot reads as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_valid) begin
            mem[wr_addr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dbg_meta <= 1'b0;
            dbg_sync <= 1'b0;
            dbg_prev <= 1'b0;
        end else begin
            dbg_meta <= debug;
            dbg_sync <= dbg_meta;
            dbg_prev <= dbg_sync;
        end
    end

    assign dbg_rise = dbg_sync && !dbg_prev;
    assign dbg_next = dbg_ptr + 1'b1;
    // stop at the last address or in front of the first empty word
    assign can_step = (dbg_ptr != '1) && (mem[dbg_next] != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            dbg_ptr <= '0;
        end else if (mode != MODE_DEBUG) begin
            // every new debug session begins at word 0
            dbg_ptr <= '0;
        end else if (dbg_rise && can_step) begin
            dbg_ptr <= dbg_next;
        end
    end

    // registered read port shared by debug walk and cpu fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_out <= '0;
        end else begin
            case (mode)
                MODE_DEBUG: begin
                    instr_out <= mem[dbg_ptr];
                end
                MODE_FETCH, 2'd3: begin
                    instr_out <= mem[fetch_addr];
                end
                default: begin
                    // load mode keeps the last word on the output
                    instr_out <= instr_out;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: instr_loader_top.sv
`timescale 1ns/1ns
`default_nettype none

module instr_loader_top import ild_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   rx,
    input  wire logic [1:0]             mode,
    input  wire logic                   debug,
    input  wire logic [ADDR_WIDTH-1:0]  fetch_addr,
    output logic [INSTR_WIDTH-1:0]      instr_out,
    output logic [ADDR_WIDTH:0]         instr_count
);

    // receiver to assembler
    logic [7:0] rx_byte;
    logic       rx_valid;

    // assembler to store
    logic                   wr_valid;
    logic [ADDR_WIDTH-1:0]  wr_addr;
    logic [INSTR_WIDTH-1:0] wr_word;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    // packs six separated bytes into one instruction word
    instr_assembler u_instr_assembler (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .wr_valid    (wr_valid),
        .wr_addr     (wr_addr),
        .wr_word     (wr_word),
        .instr_count (instr_count)
    );

    instr_ram u_instr_ram (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .debug      (debug),
        .fetch_addr (fetch_addr),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_word    (wr_word),
        .instr_out  (instr_out)
    );

endmodule

`default_nettype wire

// File: tb_instr_loader.sv
`timescale 1ns/1ns
`default_nettype none

module tb_instr_loader import ild_pkg::*; ();

    logic                   clk;
    logic                   rst;
    logic                   rx;
    logic [1:0]             mode;
    logic                   debug;
    logic [ADDR_WIDTH-1:0]  fetch_addr;
    logic [INSTR_WIDTH-1:0] instr_out;
    logic [ADDR_WIDTH:0]    instr_count;

    int value_errors;
    int other_errors;
    int step;

    instr_loader_top UUT (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .mode        (mode),
        .debug       (debug),
        .fetch_addr  (fetch_addr),
        .instr_out   (instr_out),
        .instr_count (instr_count)
    );

    always #4 clk = ~clk;

    // one uart frame, start bit low, lsb first, stop bit high, after a random idle gap
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        int         gap;
        frame = {1'b1, data, 1'b0};
        gap = $urandom % 21;
        repeat (gap * CLKS_PER_BIT) @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // idle line long enough for the receiver to deliver the last byte
    task automatic idle_line();
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic set_mode(input logic [1:0] new_mode);
        @(posedge clk);
        mode <= new_mode;
        @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic check_count(input logic [63:0] expected);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (instr_count !== expected[ADDR_WIDTH:0] && cycles < 200);
        if (cycles >= 200) begin
            $display("timeout while waiting for instr_count at step %0d", step);
            other_errors++;
        end
        if (instr_count !== expected[ADDR_WIDTH:0]) begin
            $display("[ERROR] count step %0d: expected %0d actual %0d",
                     step, expected[ADDR_WIDTH:0], instr_count);
            value_errors++;
        end
    endtask

    // address is sampled on the next edge, word shows one cycle after that
    task automatic check_fetch(input logic [63:0] addr, input logic [63:0] expected);
        @(posedge clk);
        fetch_addr <= addr[ADDR_WIDTH-1:0];
        @(posedge clk);
        @(negedge clk);
        if (instr_out !== expected[INSTR_WIDTH-1:0]) begin
            $display("[ERROR] fetch step %0d addr %0d: expected %h actual %h",
                     step, addr[ADDR_WIDTH-1:0], expected[INSTR_WIDTH-1:0], instr_out);
            value_errors++;
        end
    endtask

    // button presses of random width, long low gap so each edge settles
    task automatic check_debug(input logic [63:0] pulses, input logic [63:0] expected);
        int cycles;
        for (int i = 0; i < pulses; i++) begin
            @(posedge clk);
            debug <= 1'b1;
            repeat ($urandom % 4) @(posedge clk);
            @(posedge clk);
            debug <= 1'b0;
            repeat (6 + $urandom % 8) @(posedge clk);
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (instr_out !== expected[INSTR_WIDTH-1:0] && cycles < 20);
        if (instr_out !== expected[INSTR_WIDTH-1:0]) begin
            $display("[ERROR] debug step %0d after %0d pulses: expected %h actual %h",
                     step, pulses, expected[INSTR_WIDTH-1:0], instr_out);
            value_errors++;
        end
    endtask

    // watchdog for the whole run
    initial begin
        #2000000;
        $display("watchdog expired before the stimulus file was finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_flow
        int               fd;
        int               code;
        int               rnd;
        logic             done;
        logic [127:0]     tok;
        logic [8*100-1:0] rest;
        logic [63:0]      arg_a;
        logic [63:0]      arg_b;
        clk = 1'b0;
        rst = 1'b1;
        rx = 1'b1;
        mode = MODE_LOAD;
        debug = 1'b0;
        fetch_addr = '0;
        value_errors = 0;
        other_errors = 0;
        step = 0;
        rnd = $urandom(32'h73b6);
        apply_reset();
        fd = $fopen("instr_loader_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open instr_loader_stim.txt");
            other_errors++;
        end
        done = (fd == 0);
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                step++;
                case (tok)
                    "#": code = $fgets(rest, fd);
                    "L": begin
                        // every data byte is followed by its separator
                        for (int i = 0; i < BYTES_PER_INSTR; i++) begin
                            code = $fscanf(fd, "%h", arg_a);
                            send_byte(arg_a[7:0]);
                            send_byte(SEP_BYTE);
                        end
                        idle_line();
                    end
                    "P": begin
                        code = $fscanf(fd, "%h", arg_b);
                        for (int i = 0; i < arg_b; i++) begin
                            code = $fscanf(fd, "%h", arg_a);
                            send_byte(arg_a[7:0]);
                        end
                        idle_line();
                    end
                    "M": begin
                        code = $fscanf(fd, "%h", arg_a);
                        set_mode(arg_a[1:0]);
                    end
                    "F": begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        check_fetch(arg_a, arg_b);
                    end
                    "D": begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        check_debug(arg_a, arg_b);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h", arg_a);
                        check_count(arg_a);
                    end
                    "R": apply_reset();
                    default: begin
                        $display("unknown command in stimulus file at step %0d", step);
                        other_errors++;
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("errors: value %0d, other %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: instr_loader_stim.txt
# cmd and hex args: L six bytes, P count and raw bytes, M mode, F addr word
# D pulses word, C count, R reset
M 0
L 1a 2b 11 22 33 44
L 35 06 de ad be ef
L ff ff 01 02 03 04
L 80 01 a5 5a 0f f0
C 4
M 2
F 0 2b11223344
F 1 16deadbeef
F 3 1a55a0ff0
M 3
F 2 3f01020304
M 1
D 0 2b11223344
D 2 3f01020304
D 3 1a55a0ff0
M 2
M 1
D 0 2b11223344
L 77 66 55 44 33 22
M 2
L 01 02 03 04 05 06
C 4
F 4 0
M 0
P 12 09 0c 24 01 02 24 aa bb cc 24 55 55 24 7e 24 81 81 24
P 5 3c 24 9d 24 e7
M 2
M 0
L 4b 01 10 20 30 40
C 6
M 2
F 4 32cc557e81
F 5 2d10203040
R
C 0
F 0 0
F 5 0

// File: tb.f
ild_pkg.sv
uart_rx.sv
instr_assembler.sv
instr_ram.sv
instr_loader_top.sv
tb_instr_loader.sv
